// File: design/bus_decoder.sv
/* address decoder of the system bus, classifies requests
   and forwards a valid-gated copy to memory and GPIO */
module bus_decoder (
  // request from the bus master
  input  soc_pkg::bus_req_t req,
  // one-hot target of the request
  output soc_pkg::region_t  region,
  // gated requests toward the targets
  output soc_pkg::bus_req_t mem_req,
  output soc_pkg::bus_req_t gpio_req
);

  import soc_pkg::*;

  ////////////////////
  // address decode
  ////////////////////

  // peripheral region bit
  logic per_sel;
  // UART slot bit inside peripherals
  logic uart_sel;

  assign per_sel  = req.adr[PER_SEL_BIT];
  assign uart_sel = req.adr[UART_SEL_BIT];

  // region flags, not qualified by valid
  // response stage qualifies them later
  always_comb begin
    region.mem      = ~per_sel;
    region.gpio     =  per_sel & ~uart_sel;
    region.unmapped =  per_sel &  uart_sel;
  end

  ////////////////////
  // request fan-out
  ////////////////////

  // data memory sees every field
  // valid only when addressed
  always_comb begin
    mem_req     = req;
    mem_req.vld = req.vld & region.mem;
  end

  // GPIO controller, same rule
  always_comb begin
    gpio_req     = req;
    gpio_req.vld = req.vld & region.gpio;
  end

  // unmapped slot has no target
  // no valid leaves the decoder for it
  // so UART accesses change no state

endmodule: bus_decoder

// File: design/data_memory.sv
/* byte-enabled data memory, single port
   read-first with registered read data */
module data_memory (
  input  logic                    clk,
  input  logic                    rst,
  // gated request from the decoder
  input  soc_pkg::bus_req_t       req,
  // read word, one cycle after the request
  output logic [soc_pkg::XLEN-1:0] rdt
);

  import soc_pkg::*;

  // 2^MEM_ADR_W words
  localparam int unsigned DEPTH = 2**MEM_ADR_W;

  // storage array, contents survive reset
  logic [XLEN-1:0] mem [DEPTH];

  // word index, upper address bits alias
  logic [MEM_ADR_W-1:0] idx;

  assign idx = req.adr[BLOG +: MEM_ADR_W];

  ////////////////////
  // write path
  ////////////////////

  // enabled bytes only
  always_ff @(posedge clk) begin
    if (req.vld && req.wen) begin
      for (int unsigned b = 0; b < BLEN; b++) begin
        if (req.ben[b]) begin
          mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
        end
      end
    end
  end

  ////////////////////
  // read path
  ////////////////////

  // old word on a same-cycle write
  // holds between requests
  always_ff @(posedge clk) begin
    if (rst) begin
      rdt <= '0;
    end else if (req.vld) begin
      rdt <= mem[idx];
    end
  end

endmodule: data_memory

// File: design/degu_soc_top.sv
/* load/store side of the SoC, decoder, data memory,
   GPIO controller and response stage */
module degu_soc_top (
  input  logic                       clk,
  input  logic                       rst,
  // system bus from the master
  input  soc_pkg::bus_req_t          req,
  output soc_pkg::bus_rsp_t          rsp,
  // GPIO pins
  input  logic [soc_pkg::GPIO_W-1:0] gpio_pins,
  output logic [soc_pkg::GPIO_W-1:0] gpio_drive,
  output logic [soc_pkg::GPIO_W-1:0] gpio_enable
);

  import soc_pkg::*;

  // decoded target
  region_t         region;
  // gated requests
  bus_req_t        mem_req;
  bus_req_t        gpio_req;
  // target read data
  logic [XLEN-1:0] mem_rdt;
  logic [XLEN-1:0] gpio_rdt;

  ////////////////////
  // request side
  ////////////////////

  bus_decoder bus_decoder_i (
    .req      (req),
    .region   (region),
    .mem_req  (mem_req),
    .gpio_req (gpio_req)
  );

  ////////////////////
  // targets
  ////////////////////

  data_memory data_memory_i (
    .clk (clk),
    .rst (rst),
    .req (mem_req),
    .rdt (mem_rdt)
  );

  gpio_controller gpio_controller_i (
    .clk         (clk),
    .rst         (rst),
    .req         (gpio_req),
    .gpio_pins   (gpio_pins),
    .gpio_drive  (gpio_drive),
    .gpio_enable (gpio_enable),
    .rdt         (gpio_rdt)
  );

  // response side, ungated valid
  response_mux response_mux_i (
    .clk      (clk),
    .rst      (rst),
    .region   (region),
    .req_vld  (req.vld),
    .mem_rdt  (mem_rdt),
    .gpio_rdt (gpio_rdt),
    .rsp      (rsp)
  );

endmodule: degu_soc_top

// File: design/gpio_controller.sv
/* GPIO controller with output, output-enable and pin registers
   byte-enabled writes and registered reads */
module gpio_controller (
  input  logic                      clk,
  input  logic                      rst,
  // gated request from the decoder
  input  soc_pkg::bus_req_t         req,
  // pin side
  input  logic [soc_pkg::GPIO_W-1:0] gpio_pins,
  output logic [soc_pkg::GPIO_W-1:0] gpio_drive,
  output logic [soc_pkg::GPIO_W-1:0] gpio_enable,
  // register read data
  output logic [soc_pkg::XLEN-1:0]   rdt
);

  import soc_pkg::*;

  // merge enabled bytes of new into old
  function automatic logic [XLEN-1:0] byte_merge(
    input logic [XLEN-1:0] old,
    input logic [XLEN-1:0] wdt,
    input logic [BLEN-1:0] ben
  );
    logic [XLEN-1:0] res;
    res = old;
    for (int unsigned b = 0; b < BLEN; b++) begin
      if (ben[b]) begin
        res[8*b +: 8] = wdt[8*b +: 8];
      end
    end
    return res;
  endfunction: byte_merge

  // register offset, address bits [3:2]
  logic [GPIO_OFS_W-1:0] ofs;
  // write and read strobes
  logic                  wr;
  logic                  rd;

  assign ofs = req.adr[BLOG +: GPIO_OFS_W];
  assign wr  = req.vld &  req.wen;
  assign rd  = req.vld & ~req.wen;

  ////////////////////
  // control registers
  ////////////////////

  // output value, seen on pins next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      gpio_drive <= '0;
    end else if (wr && (ofs == GPIO_REG_OUT)) begin
      gpio_drive <= GPIO_W'(byte_merge(XLEN'(gpio_drive), req.wdt, req.ben));
    end
  end

  // output enable, one bit per pin
  always_ff @(posedge clk) begin
    if (rst) begin
      gpio_enable <= '0;
    end else if (wr && (ofs == GPIO_REG_ENA)) begin
      gpio_enable <= GPIO_W'(byte_merge(XLEN'(gpio_enable), req.wdt, req.ben));
    end
  end

  ////////////////////
  // read path
  ////////////////////

  // values before a same-cycle write
  // pins sampled in the request cycle
  always_ff @(posedge clk) begin
    if (rd) begin
      case (ofs)
        GPIO_REG_OUT: rdt <= XLEN'(gpio_drive);
        GPIO_REG_ENA: rdt <= XLEN'(gpio_enable);
        GPIO_REG_PIN: rdt <= XLEN'(gpio_pins);
        // offset 3 is empty
        default:      rdt <= '0;
      endcase
    end
  end

endmodule: gpio_controller

// File: design/response_mux.sv
/* one-cycle response stage, registers request valid and region
   and selects the read data or an error for the response */
module response_mux (
  input  logic                     clk,
  input  logic                     rst,
  // decoded target of the current request
  input  soc_pkg::region_t         region,
  // valid of the current request
  input  logic                     req_vld,
  // target read data, already registered
  input  logic [soc_pkg::XLEN-1:0] mem_rdt,
  input  logic [soc_pkg::XLEN-1:0] gpio_rdt,
  // response to the bus master
  output soc_pkg::bus_rsp_t        rsp
);

  import soc_pkg::*;

  ////////////////////
  // request stage
  ////////////////////

  // request in flight
  logic    rsp_vld_q;
  // region of the request in flight
  region_t region_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_vld_q <= 1'b0;
      region_q  <= '0;
    end else begin
      rsp_vld_q <= req_vld;
      region_q  <= region;
    end
  end

  ////////////////////
  // response select
  ////////////////////

  // targets hold their data until the next request
  // unmapped slot answers zero with error
  always_comb begin
    rsp.vld = rsp_vld_q;
    rsp.err = rsp_vld_q & region_q.unmapped;
    if (region_q.mem) begin
      rsp.rdt = mem_rdt;
    end else if (region_q.gpio) begin
      rsp.rdt = gpio_rdt;
    end else begin
      rsp.rdt = '0;
    end
  end

endmodule: response_mux

// File: design/soc_pkg.sv
/* bus widths, address map and GPIO register offsets
   request, response and region structs of the system bus */
package soc_pkg;

  ////////////////////
  // widths
  ////////////////////

  // data and address width
  localparam int unsigned XLEN = 32;
  // bytes per word, also byte enable width
  localparam int unsigned BLEN = XLEN/8;
  // address bits below word alignment
  localparam int unsigned BLOG = $clog2(BLEN);

  ////////////////////
  // address map
  ////////////////////

  // data memory word address bits, aliases above
  localparam int unsigned MEM_ADR_W = 10;
  // peripheral region select, zero is data memory
  localparam int unsigned PER_SEL_BIT = 14;
  // inside peripherals, one selects the UART slot
  localparam int unsigned UART_SEL_BIT = 6;

  // GPIO pin count
  localparam int unsigned GPIO_W = 32;
  // GPIO register word offset, address bits [3:2]
  localparam int unsigned GPIO_OFS_W = 2;
  localparam logic [GPIO_OFS_W-1:0] GPIO_REG_OUT = 2'd0;
  localparam logic [GPIO_OFS_W-1:0] GPIO_REG_ENA = 2'd1;
  localparam logic [GPIO_OFS_W-1:0] GPIO_REG_PIN = 2'd2;

  ////////////////////
  // bus structs
  ////////////////////

  // request from the bus master, 70 bits
  typedef struct packed {
    logic            vld;
    logic            wen;
    logic [XLEN-1:0] adr;
    logic [BLEN-1:0] ben;
    logic [XLEN-1:0] wdt;
  } bus_req_t;

  // response, one cycle after the request
  typedef struct packed {
    logic            vld;
    logic [XLEN-1:0] rdt;
    logic            err;
  } bus_rsp_t;

  // one-hot target of a request
  typedef struct packed {
    logic mem;
    logic gpio;
    logic unmapped;
  } region_t;

endpackage: soc_pkg

// File: filelist.f
design/soc_pkg.sv
design/bus_decoder.sv
design/data_memory.sv
design/gpio_controller.sv
design/response_mux.sv
design/degu_soc_top.sv
verification/degu_soc_asserts.sv
verification/degu_soc_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the SoC testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module degu_soc_tb \
  --Mdir "$build_dir" \
  -o degu_soc_sim \
  -f filelist.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$build_dir/degu_soc_sim" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$log"; then
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$log"; then
  echo "no result line in the log"
  exit 1
fi
exit 0

// File: verification/degu_soc_asserts.sv
/* bound assertions on the response stage, valid timing,
   error flag and state after reset */
module degu_soc_asserts (
  input logic              clk,
  input logic              rst,
  // request valid into the stage
  input logic              req_vld,
  // registered region of the request in flight
  input soc_pkg::region_t  region_q,
  // response to the bus master
  input soc_pkg::bus_rsp_t rsp
);

  // response one cycle behind the request
  a_vld_follows: assert property (
    @(posedge clk) disable iff (rst) rsp.vld == $past(req_vld)
  ) else $error("response valid does not follow request valid by one cycle");

  // error only from the UART slot alone, with zero data
  a_err_unmapped: assert property (
    @(posedge clk) disable iff (rst)
      rsp.err |-> $onehot(region_q) && region_q.unmapped && (rsp.rdt == '0)
  ) else $error("error flag raised outside the unmapped region or with data");

  // idle bus right after reset
  a_reset_idle: assert property (
    @(posedge clk) rst |=> !rsp.vld
  ) else $error("response valid high in the cycle after reset");

endmodule: degu_soc_asserts

bind response_mux degu_soc_asserts degu_soc_asserts_i (
  .clk      (clk),
  .rst      (rst),
  .req_vld  (req_vld),
  .region_q (region_q),
  .rsp      (rsp)
);

// File: verification/degu_soc_tb.sv
/* testbench of the SoC load/store side, stimulus, reference model
   and response compare */
module degu_soc_tb;

  import soc_pkg::*;

  // expected response of one request
  typedef struct packed {
    int                due;
    logic              err;
    logic              chk_rdt;
    logic [XLEN-1:0]   rdt;
    logic [GPIO_W-1:0] drive;
    logic [GPIO_W-1:0] enable;
  } exp_t;

  logic              clk;
  logic              rst;
  bus_req_t          req;
  bus_rsp_t          rsp;
  logic [GPIO_W-1:0] gpio_pins;
  logic [GPIO_W-1:0] gpio_drive;
  logic [GPIO_W-1:0] gpio_enable;

  integer seed;
  int     cyc = 0;
  int     errors = 0;
  int     checks = 0;
  // one entry per request in flight
  exp_t   exp_q[$];

  // reference state, memory and GPIO register images
  logic [XLEN-1:0]   shadow_mem [2**MEM_ADR_W];
  logic [GPIO_W-1:0] ref_drive = '0;
  logic [GPIO_W-1:0] ref_enable = '0;

  degu_soc_top degu_soc_top_i (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .rsp         (rsp),
    .gpio_pins   (gpio_pins),
    .gpio_drive  (gpio_drive),
    .gpio_enable (gpio_enable)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // cycle count, stamps each request
  always @(posedge clk) cyc <= cyc + 1;

  ////////////////////
  // helpers
  ////////////////////

  task automatic check(input string name, input logic [XLEN-1:0] got,
                       input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [XLEN-1:0] rnd();
    return $random(seed);
  endfunction

  function automatic logic [BLEN-1:0] rnd_ben();
    logic [XLEN-1:0] t;
    t = $random(seed);
    return t[BLEN-1:0];
  endfunction

  // byte lanes of wdt replace old where enabled
  function automatic logic [XLEN-1:0] merge_bytes(input logic [XLEN-1:0] old,
      input logic [XLEN-1:0] wdt, input logic [BLEN-1:0] ben);
    logic [XLEN-1:0] mask;
    mask = {{8{ben[3]}}, {8{ben[2]}}, {8{ben[1]}}, {8{ben[0]}}};
    return (old & ~mask) | (wdt & mask);
  endfunction

  // memory word w, random alias and byte bits
  function automatic logic [XLEN-1:0] mem_addr(input int unsigned w);
    logic [XLEN-1:0] a;
    a = $random(seed);
    a[PER_SEL_BIT] = 1'b0;
    a[MEM_ADR_W+1:2] = MEM_ADR_W'(w);
    return a;
  endfunction

  function automatic logic [XLEN-1:0] gpio_addr(input logic [1:0] ofs);
    logic [XLEN-1:0] a;
    a = $random(seed);
    a[PER_SEL_BIT] = 1'b1;
    a[UART_SEL_BIT] = 1'b0;
    a[3:2] = ofs;
    return a;
  endfunction

  function automatic logic [XLEN-1:0] uart_addr();
    logic [XLEN-1:0] a;
    a = $random(seed);
    a[PER_SEL_BIT] = 1'b1;
    a[UART_SEL_BIT] = 1'b1;
    return a;
  endfunction

  ////////////////////
  // reference model
  ////////////////////

  // read-first, then the write updates the images
  function automatic exp_t ref_response(input bus_req_t r, input logic [GPIO_W-1:0] pins);
    exp_t                 e;
    logic [MEM_ADR_W-1:0] idx;
    e = '0;
    e.due = cyc + 1;
    e.chk_rdt = ~r.wen;
    idx = r.adr[MEM_ADR_W+1:2];
    if (!r.adr[PER_SEL_BIT]) begin
      e.rdt = shadow_mem[idx];
      if (r.wen) shadow_mem[idx] = merge_bytes(shadow_mem[idx], r.wdt, r.ben);
    end else if (r.adr[UART_SEL_BIT]) begin
      // absent UART, error and zero data even on writes
      // no state change
      e.err = 1'b1;
      e.chk_rdt = 1'b1;
    end else begin
      case (r.adr[3:2])
        2'd0: e.rdt = ref_drive;
        2'd1: e.rdt = ref_enable;
        2'd2: e.rdt = pins;
        default: e.rdt = '0;
      endcase
      if (r.wen && r.adr[3:2] == 2'd0) ref_drive = merge_bytes(ref_drive, r.wdt, r.ben);
      if (r.wen && r.adr[3:2] == 2'd1) ref_enable = merge_bytes(ref_enable, r.wdt, r.ben);
    end
    e.drive = ref_drive;
    e.enable = ref_enable;
    return e;
  endfunction

  ////////////////////
  // stimulus
  ////////////////////

  // one request in the next cycle
  task automatic issue(input logic wen, input logic [XLEN-1:0] adr,
                       input logic [BLEN-1:0] ben, input logic [XLEN-1:0] wdt,
                       input logic [GPIO_W-1:0] pins);
    bus_req_t r;
    @(posedge clk);
    #1;
    r.vld = 1'b1;
    r.wen = wen;
    r.adr = adr;
    r.ben = ben;
    r.wdt = wdt;
    req = r;
    gpio_pins = pins;
    exp_q.push_back(ref_response(r, pins));
  endtask

  task automatic idle();
    @(posedge clk);
    #1;
    req.vld = 1'b0;
  endtask

  ////////////////////
  // compare
  ////////////////////

  // a response is due exactly one cycle after its request
  always @(negedge clk) begin
    exp_t e;
    if (exp_q.size() > 0 && cyc >= exp_q[0].due) begin
      e = exp_q.pop_front();
      check("rsp.vld", 32'(rsp.vld), 32'd1);
      check("rsp.err", 32'(rsp.err), 32'(e.err));
      if (e.chk_rdt) check("rsp.rdt", rsp.rdt, e.rdt);
      check("gpio_drive", gpio_drive, e.drive);
      check("gpio_enable", gpio_enable, e.enable);
    end else if (!rst) begin
      check("rsp.vld", 32'(rsp.vld), 32'd0);
    end
  end

  initial begin
    logic [XLEN-1:0] sel;
    logic [XLEN-1:0] adr;
    int unsigned     k;
    int              wait_cnt;
    seed = 32'h641d_dff6;
    rst = 1'b1;
    req = '0;
    gpio_pins = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // quiet bus after reset
    repeat (3) @(negedge clk);
    check("gpio_drive", gpio_drive, 32'h0);
    check("gpio_enable", gpio_enable, 32'h0);
    check("rsp.vld", 32'(rsp.vld), 32'd0);

    // fill a 64 word window, then partial writes, then reads back to back
    for (k = 0; k < 64; k++) issue(1'b1, mem_addr(k), 4'hf, rnd(), rnd());
    for (k = 0; k < 48; k++) issue(1'b1, mem_addr(rnd() & 32'd63), rnd_ben(), rnd(), rnd());
    for (k = 0; k < 64; k++) issue(1'b0, mem_addr(k), 4'h0, 32'h0, rnd());
    idle();

    // GPIO output and enable, byte lanes
    issue(1'b1, gpio_addr(2'd0), 4'b0101, 32'ha5c3_3c5a, rnd());
    issue(1'b1, gpio_addr(2'd1), 4'b1100, 32'hf00f_0ff0, rnd());
    issue(1'b1, gpio_addr(2'd0), 4'b1010, 32'h1234_5678, rnd());
    for (k = 0; k < 8; k++) issue(1'b1, gpio_addr(2'(k & 1)), rnd_ben(), rnd(), rnd());
    issue(1'b0, gpio_addr(2'd0), 4'h0, 32'h0, rnd());
    issue(1'b0, gpio_addr(2'd1), 4'h0, 32'h0, rnd());
    idle();

    // pin reads, empty offset, writes there change nothing
    issue(1'b0, gpio_addr(2'd2), 4'h0, 32'h0, 32'hdead_beef);
    issue(1'b0, gpio_addr(2'd2), 4'h0, 32'h0, 32'h1234_5678);
    issue(1'b1, gpio_addr(2'd3), 4'hf, rnd(), rnd());
    issue(1'b1, gpio_addr(2'd2), 4'hf, rnd(), rnd());
    issue(1'b0, gpio_addr(2'd3), 4'h0, 32'h0, rnd());
    idle();

    // UART slot, then readback of GPIO and memory
    // word bits inside the filled window, UART bit is word bit 4
    for (k = 0; k < 6; k++) begin
      adr = uart_addr();
      adr[MEM_ADR_W+1:2] = MEM_ADR_W'(16 + k);
      issue(k[0], adr, 4'hf, rnd(), rnd());
    end
    issue(1'b0, gpio_addr(2'd0), 4'h0, 32'h0, rnd());
    issue(1'b0, gpio_addr(2'd1), 4'h0, 32'h0, rnd());
    for (k = 16; k < 22; k++) issue(1'b0, mem_addr(k), 4'h0, 32'h0, rnd());
    idle();

    // random mix, a request every cycle
    for (k = 0; k < 300; k++) begin
      sel = rnd();
      case (sel[1:0])
        2'd0, 2'd1: issue(sel[2], mem_addr(rnd() & 32'd63), rnd_ben(), rnd(), rnd());
        2'd2:       issue(sel[2], gpio_addr(sel[5:4]), rnd_ben(), rnd(), rnd());
        default:    issue(sel[2], uart_addr(), rnd_ben(), rnd(), rnd());
      endcase
    end
    idle();

    // drain what is still in flight
    wait_cnt = 0;
    while (exp_q.size() > 0 && wait_cnt < 20) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (exp_q.size() > 0) begin
      errors++;
      $display("timeout, %0d responses never arrived", exp_q.size());
    end

    $display("errors %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule: degu_soc_tb
